//--- nn_defines.svh
`ifndef NN_DEFINES_SVH
`define NN_DEFINES_SVH

// activations in one input vector
`define NN_NUM_INPUTS 15

// neurons side by side in the layer
`define NN_NUM_NODES 4

// activation weight bias and result width
`define NN_DATA_WIDTH 16

// register stages inside one neuron
`define NN_PIPE_DEPTH 3

`endif

//--- nnPkg.sv
`include "nn_defines.svh"

package nnPkg;

	// one activation or one node result
	typedef logic [`NN_DATA_WIDTH-1:0] act_t;

	// two's-complement weight or bias
	typedef logic [`NN_DATA_WIDTH-1:0] weight_t;

	typedef logic [$clog2(`NN_NUM_NODES)-1:0] nodeIdx_t;

	// last word of a row holds the bias
	typedef logic [$clog2(`NN_NUM_INPUTS+1)-1:0] wordIdx_t;

	typedef act_t actVec_t [`NN_NUM_INPUTS];

	typedef weight_t weightRow_t [`NN_NUM_INPUTS];

	// state of the result register in front of outData
	typedef enum logic
	{
		EMPTY,
		HOLDING
	} pipeState_t;

endpackage

//--- layerBusIf.sv
`timescale 1ns/100ps
`include "nn_defines.svh"

interface layerBusIf;

	// activations unpacked by the top before capture
	nnPkg::actVec_t inActs;

	// captured vector shared by stage 1 of every node
	nnPkg::actVec_t acts;

	// common enable for every pipeline register
	logic advance;

	nnPkg::weightRow_t weights [`NN_NUM_NODES];
	nnPkg::weight_t biases [`NN_NUM_NODES];

	// one result per node from the ReLU stage
	nnPkg::act_t results [`NN_NUM_NODES];

	modport ctrl
	(
		input inActs,
		output acts,
		output advance
	);

	modport store
	(
		output weights,
		output biases
	);

	// rows and results go through the neuron's own ports
	modport node
	(
		input acts,
		input advance
	);

endinterface

//--- weightStore.sv
`timescale 1ns/100ps
`include "nn_defines.svh"

module weightStore
(
	input logic clk,
	input logic reset,
	input logic wEn,
	input nnPkg::nodeIdx_t wNode,
	input nnPkg::wordIdx_t wWord,
	input nnPkg::weight_t wData,
	layerBusIf.store bus
);

	localparam int NODES = `NN_NUM_NODES;
	localparam int INPUTS = `NN_NUM_INPUTS;

	// weights first then the bias word
	localparam int WORDS = INPUTS + 1;
	localparam int BIAS_WORD = INPUTS;

	nnPkg::weight_t regFile [NODES][WORDS];

	// all words start at zero so an unloaded layer outputs zero
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < NODES; n++)
			begin
				for (int w = 0; w < WORDS; w++)
				begin
					regFile[n][w] <= '0;
				end
			end
		end
		else if (wEn)
		begin
			regFile[wNode][wWord] <= wData;
		end
	end

	// every row is visible to the neurons all the time
	for (genvar n = 0; n < NODES; n++)
	begin : gRow
		for (genvar w = 0; w < INPUTS; w++)
		begin : gWord
			assign bus.weights[n][w] = regFile[n][w];
		end

		assign bus.biases[n] = regFile[n][BIAS_WORD];
	end

endmodule

//--- neuron.sv
`timescale 1ns/100ps
`include "nn_defines.svh"

module neuron
(
	input logic clk,
	input logic reset,
	layerBusIf.node bus,
	input nnPkg::weightRow_t weights,
	input nnPkg::weight_t bias,
	output nnPkg::act_t result
);

	localparam int INPUTS = `NN_NUM_INPUTS;
	localparam int SIGN_BIT = `NN_DATA_WIDTH - 1;

	nnPkg::actVec_t actReg;
	nnPkg::act_t products [INPUTS];
	nnPkg::act_t macSum;
	nnPkg::act_t sumReg;

	// stage 1 holds the shared activation vector
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '{default: '0};
		end
		else if (bus.advance)
		begin
			actReg <= bus.acts;
		end
	end

	// only the low half of each product is kept
	always_comb
	begin
		for (int i = 0; i < INPUTS; i++)
		begin
			products[i] = actReg[i] * weights[i];
		end
	end

	// sum wraps modulo 2^16 like the products
	always_comb
	begin
		macSum = bias;
		for (int i = 0; i < INPUTS; i++)
		begin
			macSum = macSum + products[i];
		end
	end

	// stage 2
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else if (bus.advance)
		begin
			sumReg <= macSum;
		end
	end

	// stage 3 applies the ReLU on the sign bit
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else if (bus.advance)
		begin
			if (sumReg[SIGN_BIT])
			begin
				result <= '0;
			end
			else
			begin
				result <= sumReg;
			end
		end
	end

endmodule

//--- layerControl.sv
`timescale 1ns/100ps
`include "nn_defines.svh"

module layerControl
(
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	output logic outValid,
	input logic outReady,
	layerBusIf.ctrl bus
);

	localparam int DEPTH = `NN_PIPE_DEPTH;

	// bit 0 tracks the capture register and the rest the neuron stages before the ReLU
	// the ReLU stage itself is tracked by outState
	logic [DEPTH-1:0] stageValid;

	nnPkg::pipeState_t outState;
	nnPkg::pipeState_t outStateNext;

	logic advance;
	logic inFire;

	// whole pipeline moves unless a held result is refused
	assign advance = (outState == nnPkg::EMPTY) || outReady;
	assign inFire = inValid && advance;

	assign inReady = advance;
	assign outValid = (outState == nnPkg::HOLDING);
	assign bus.advance = advance;

	// input vector is captured only on a transfer
	always_ff @(posedge clk)
	begin
		if (inFire)
		begin
			bus.acts <= bus.inActs;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stageValid <= '0;
		end
		else if (advance)
		begin
			stageValid <= {stageValid[DEPTH-2:0], inValid};
		end
	end

	always_comb
	begin
		outStateNext = outState;
		case (outState)
			nnPkg::EMPTY:
			begin
				if (stageValid[DEPTH-1])
				begin
					outStateNext = nnPkg::HOLDING;
				end
			end
			nnPkg::HOLDING:
			begin
				// accepted result can be replaced on the same edge
				if (outReady && !stageValid[DEPTH-1])
				begin
					outStateNext = nnPkg::EMPTY;
				end
			end
			default:
			begin
				outStateNext = nnPkg::EMPTY;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outState <= nnPkg::EMPTY;
		end
		else
		begin
			outState <= outStateNext;
		end
	end

endmodule

//--- nnLayer.sv
`timescale 1ns/100ps
`include "nn_defines.svh"

module nnLayer
(
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input logic [`NN_NUM_INPUTS*`NN_DATA_WIDTH-1:0] inData,
	output logic outValid,
	input logic outReady,
	output logic [`NN_NUM_NODES*`NN_DATA_WIDTH-1:0] outData,
	input logic wEn,
	input nnPkg::nodeIdx_t wNode,
	input nnPkg::wordIdx_t wWord,
	input nnPkg::weight_t wData
);

	localparam int INPUTS = `NN_NUM_INPUTS;
	localparam int NODES = `NN_NUM_NODES;
	localparam int WIDTH = `NN_DATA_WIDTH;

	layerBusIf bus();

	// activation 0 sits in the low bits of inData
	for (genvar i = 0; i < INPUTS; i++)
	begin : gUnpack
		assign bus.inActs[i] = inData[i*WIDTH +: WIDTH];
	end

	layerControl control0
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.outValid(outValid),
		.outReady(outReady),
		.bus(bus.ctrl)
	);

	weightStore store0
	(
		.clk(clk),
		.reset(reset),
		.wEn(wEn),
		.wNode(wNode),
		.wWord(wWord),
		.wData(wData),
		.bus(bus.store)
	);

	// each node gets only its own row and bias
	for (genvar n = 0; n < NODES; n++)
	begin : gNode
		neuron node
		(
			.clk(clk),
			.reset(reset),
			.bus(bus.node),
			.weights(bus.weights[n]),
			.bias(bus.biases[n]),
			.result(bus.results[n])
		);

		// node 0 lands in the low bits of outData
		assign outData[n*WIDTH +: WIDTH] = bus.results[n];
	end

endmodule

//--- tb_nnLayer.sv
`timescale 1ns/100ps
`include "nn_defines.svh"

module tb_nnLayer;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 10;
	localparam int NODES = `NN_NUM_NODES;
	localparam int INPUTS = `NN_NUM_INPUTS;
	localparam int WIDTH = `NN_DATA_WIDTH;
	localparam int IN_BITS = INPUTS * WIDTH;
	localparam int OUT_BITS = NODES * WIDTH;
	localparam int LOAD_CYCLES = 2 * NODES * (INPUTS + 1);
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + RESET_CYCLES + LOAD_CYCLES;
	localparam logic [31:0] SEED = 32'h9fe8_f102;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic inValid = 1'b0;
	logic inReady;
	logic [IN_BITS-1:0] inData = '0;
	logic outValid;
	logic outReady = 1'b1;
	logic [OUT_BITS-1:0] outData;
	logic wEn = 1'b0;
	nnPkg::nodeIdx_t wNode = '0;
	nnPkg::wordIdx_t wWord = '0;
	nnPkg::weight_t wData = '0;

	// expected register file contents with the bias in word 15
	logic [WIDTH-1:0] shadow [NODES][INPUTS+1] = '{default: '0};

	logic [OUT_BITS-1:0] expQueue [$];
	string nameQueue [$];
	logic [OUT_BITS-1:0] popExpected;
	string popName;
	string currentName = "reset";
	bit randomReady = 1'b0;
	bit readyPattern [TIMEOUT_CYCLES];
	int readyIndex = 0;
	logic readyNext;
	bit holdValid = 1'b0;
	logic [OUT_BITS-1:0] holdData;
	int errorCount = 0;
	int zeroCount = 0;
	int positiveCount = 0;
	int loadedSet;
	int waits;
	int cycles;

	// set 1 changes node 2 only
	string testNames [NUM_TESTS] = '{"basic", "relu_neg", "wrap_big", "mixed", "stall_a",
		"stall_b", "stall_neg", "stall_mixed", "reload_basic", "reload_mixed"};
	int weightSets [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1};
	bit readyFlags [NUM_TESTS] = '{0, 0, 0, 0, 1, 1, 1, 1, 0, 1};

	// activation 0 sits in the low bits as on inData
	logic [IN_BITS-1:0] actTable [NUM_TESTS] = '{
		{80'h0001_0002_0003_0004_0005, 80'h0006_0007_0008_0009_000a, 80'h000b_000c_000d_000e_000f},
		{80'hffff_fffe_fffd_fffc_fffb, 80'hfffa_fff9_fff8_fff7_fff6, 80'hfff5_fff4_fff3_fff2_fff1},
		{80'h7fff_7fff_7fff_7fff_7fff, 80'h8000_8000_8000_8000_8000, 80'h7fff_8000_7fff_8000_7fff},
		{80'h1234_8765_0f0f_f0f0_55aa, 80'haa55_0001_ffff_4000_c000, 80'h0100_ff00_3333_cccc_0042},
		{80'h0a0b_0c0d_0e0f_1011_1213, 80'h1415_1617_1819_1a1b_1c1d, 80'h1e1f_2021_2223_2425_2627},
		{80'hdead_beef_cafe_f00d_0bad, 80'h1eaf_5eed_7007_0770_abcd, 80'h00ff_ff00_8001_7ffe_0003},
		{80'hffff_fffe_fffd_fffc_fffb, 80'hfffa_fff9_fff8_fff7_fff6, 80'hfff5_fff4_fff3_fff2_fff1},
		{80'h1234_8765_0f0f_f0f0_55aa, 80'haa55_0001_ffff_4000_c000, 80'h0100_ff00_3333_cccc_0042},
		{80'h0001_0002_0003_0004_0005, 80'h0006_0007_0008_0009_000a, 80'h000b_000c_000d_000e_000f},
		{80'h1234_8765_0f0f_f0f0_55aa, 80'haa55_0001_ffff_4000_c000, 80'h0100_ff00_3333_cccc_0042}
	};

	nnLayer dut0
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData),
		.wEn(wEn),
		.wNode(wNode),
		.wWord(wWord),
		.wData(wData)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			errorCount++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// odd words get negative values so node sums swing both ways
	function automatic logic [WIDTH-1:0] weightValue(input int set, input int node,
		input int word);
		logic [WIDTH-1:0] value;
		value = WIDTH'((node + 1) * 291 + word * 1111);
		if (word % 2 == 1)
		begin
			value = -value;
		end
		if (set == 1 && node == 2)
		begin
			value = value ^ 16'h5a5a;
		end
		return value;
	endfunction

	// truncated products and a sum modulo 2^16 with zero when the sign bit is set
	function automatic logic [OUT_BITS-1:0] expectedResults(input logic [IN_BITS-1:0] acts);
		logic [OUT_BITS-1:0] results;
		logic [WIDTH-1:0] sum;
		logic [WIDTH-1:0] prod;
		for (int n = 0; n < NODES; n++)
		begin
			sum = shadow[n][INPUTS];
			for (int i = 0; i < INPUTS; i++)
			begin
				prod = acts[i*WIDTH +: WIDTH] * shadow[n][i];
				sum = sum + prod;
			end
			results[n*WIDTH +: WIDTH] = sum[WIDTH-1] ? '0 : sum;
		end
		return results;
	endfunction

	task automatic writeWord(input int node, input int word, input logic [WIDTH-1:0] value);
		wEn = 1'b1;
		wNode = nnPkg::nodeIdx_t'(node);
		wWord = nnPkg::wordIdx_t'(word);
		wData = value;
		@(posedge clk);
		#1;
		wEn = 1'b0;
		shadow[node][word] = value;
	endtask

	task automatic loadNodes(input int set, input int firstNode, input int lastNode);
		for (int n = firstNode; n <= lastNode; n++)
		begin
			for (int w = 0; w <= INPUTS; w++)
			begin
				writeWord(n, w, weightValue(set, n, w));
			end
		end
	endtask

	// holds the vector until a negedge sees inReady and returns after the transfer edge
	task automatic sendVector(input logic [IN_BITS-1:0] acts, output int tries);
		bit accepted;
		inData = acts;
		inValid = 1'b1;
		accepted = 1'b0;
		tries = 0;
		while (!accepted)
		begin
			@(negedge clk);
			tries++;
			accepted = inReady;
		end
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	task automatic waitIdle();
		@(posedge clk);
		while (expQueue.size() != 0)
		begin
			@(posedge clk);
		end
		#1;
	endtask

	// random outReady replays one pattern bit per cycle
	always @(posedge clk)
	begin
		readyNext = randomReady ? readyPattern[readyIndex] : 1'b1;
		readyIndex = (readyIndex + 1) % TIMEOUT_CYCLES;
		#1;
		outReady = readyNext;
	end

	// scoreboard samples mid-cycle where every handshake signal is settled
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (holdValid)
			begin
				checkValue("hold_valid", 1, outValid);
				checkValue("hold_data", holdData, outData);
			end
			holdValid = outValid && !outReady;
			holdData = outData;
			if (inValid && inReady)
			begin
				expQueue.push_back(expectedResults(inData));
				nameQueue.push_back(currentName);
			end
			if (outValid && outReady)
			begin
				if (expQueue.size() == 0)
				begin
					$display("DUT delivered a result with no vector pending");
					$display("Simulation FAILED");
					$fatal(1, "unexpected output");
				end
				else
				begin
					popExpected = expQueue.pop_front();
					popName = nameQueue.pop_front();
					checkValue(popName, popExpected, outData);
					for (int n = 0; n < NODES; n++)
					begin
						if (popExpected[n*WIDTH +: WIDTH] == '0)
							zeroCount++;
						else
							positiveCount++;
					end
				end
			end
		end
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, the layer stopped making progress", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		void'($urandom(SEED));
		foreach (readyPattern[k])
		begin
			readyPattern[k] = 1'($urandom_range(0, 1));
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		checkValue("reset_out_valid", 0, outValid);
		checkValue("reset_in_ready", 1, inReady);
		@(posedge clk);
		#1;

		loadNodes(0, 0, NODES - 1);
		loadedSet = 0;

		// one vector alone so outValid must rise after the third edge
		currentName = "single";
		sendVector(actTable[0], waits);
		repeat (3)
		begin
			@(negedge clk);
			checkValue("single_latency", 0, outValid);
		end
		@(negedge clk);
		checkValue("single_latency", 1, outValid);
		waitIdle();

		for (int i = 0; i < NUM_TESTS; i++)
		begin
			randomReady = readyFlags[i];
			if (weightSets[i] != loadedSet)
			begin
				waitIdle();
				loadNodes(weightSets[i], 2, 2);
				loadedSet = weightSets[i];
			end
			if (readyFlags[i])
			begin
				repeat ($urandom_range(0, 3))
				begin
					@(posedge clk);
					#1;
				end
			end
			currentName = testNames[i];
			sendVector(actTable[i], waits);
			if (!readyFlags[i])
			begin
				checkValue({testNames[i], "_accept"}, 1, waits);
			end
			// a stream group ends with the last result three edges behind its input
			if (!readyFlags[i] && (i == NUM_TESTS - 1 || readyFlags[i+1]
				|| weightSets[i+1] != weightSets[i]))
			begin
				cycles = 0;
				while (expQueue.size() != 0)
				begin
					@(posedge clk);
					cycles++;
				end
				#1;
				checkValue({testNames[i], "_drain"}, 4, cycles);
			end
		end
		waitIdle();

		if (zeroCount == 0 || positiveCount == 0)
		begin
			$display("ReLU not exercised: %0d zero and %0d positive node results",
				zeroCount, positiveCount);
			errorCount++;
		end
		if (errorCount == 0)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
		begin
			$display("Simulation FAILED");
			$fatal(1, "%0d errors", errorCount);
		end
	end

endmodule

//--- filelist.f
+incdir+.
nnPkg.sv
layerBusIf.sv
weightStore.sv
neuron.sv
layerControl.sv
nnLayer.sv
tb_nnLayer.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_nnLayer
RTL_TOP   ?= nnLayer
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -j 0
PASS_TEXT ?= Simulation PASSED

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# the log decides the verdict, the simulator exit status is not used
sim: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
